// ==== source/core_pkg.sv ====
// ##########################################################
// Core package: widths, opcodes, flag positions and the
// micro-op and register types of the 6502 subset core
// ##########################################################
package core_pkg;

        localparam int REG_WIDTH = 8;
        localparam int PC_WIDTH = 16;
        localparam logic [PC_WIDTH-1:0] RESET_PC = 16'h0200;

        // Status register bit positions
        localparam int FLAG_C = 0;
        localparam int FLAG_Z = 1;
        localparam int FLAG_D = 3;
        localparam int FLAG_V = 6;
        localparam int FLAG_N = 7;

        // Implied and branch opcodes, matched on the whole byte
        localparam logic [7:0] OP_INX = 8'hE8;
        localparam logic [7:0] OP_INY = 8'hC8;
        localparam logic [7:0] OP_DEX = 8'hCA;
        localparam logic [7:0] OP_DEY = 8'h88;
        localparam logic [7:0] OP_CLC = 8'h18;
        localparam logic [7:0] OP_SEC = 8'h38;
        localparam logic [7:0] OP_CLD = 8'hD8;
        localparam logic [7:0] OP_SED = 8'hF8;
        localparam logic [7:0] OP_CLV = 8'hB8;
        localparam logic [7:0] OP_BPL = 8'h10;
        localparam logic [7:0] OP_BCC = 8'h90;
        localparam logic [7:0] OP_BCS = 8'hB0;
        localparam logic [7:0] OP_BNE = 8'hD0;
        localparam logic [7:0] OP_BEQ = 8'hF0;
        localparam logic [7:0] OP_BVS = 8'h70;

        // Field values for the ALU and load groups
        localparam logic [1:0] CC_ALU = 2'b01;
        localparam logic [1:0] CC_LDX = 2'b10;
        localparam logic [1:0] CC_LDY = 2'b00;
        localparam logic [2:0] BBB_ALU_IMM = 3'b010;
        localparam logic [2:0] BBB_LOAD_IMM = 3'b000;
        localparam logic [2:0] AAA_ORA = 3'b000;
        localparam logic [2:0] AAA_AND = 3'b001;
        localparam logic [2:0] AAA_EOR = 3'b010;
        localparam logic [2:0] AAA_ADC = 3'b011;
        localparam logic [2:0] AAA_LOAD = 3'b101;
        localparam logic [2:0] AAA_CMP = 3'b110;
        localparam logic [2:0] AAA_SBC = 3'b111;

        typedef enum logic [2:0] {ALU_OR, ALU_AND, ALU_XOR, ALU_ADD, ALU_PASS_B} alu_op_t;
        typedef enum logic [1:0] {SRC_A, SRC_X, SRC_Y, SRC_ZERO} src_t;
        typedef enum logic [1:0] {DEST_NONE, DEST_A, DEST_X, DEST_Y} dest_t;
        typedef enum logic [2:0] {
                FLAG_KEEP, CLEAR_C, SET_C, CLEAR_D, SET_D, CLEAR_V
        } flag_op_t;
        typedef enum logic [2:0] {
                COND_NONE, COND_PL, COND_CC, COND_CS, COND_NE, COND_EQ, COND_VS
        } cond_t;

        typedef struct packed {
                logic [2:0] aaa;        // Operation
                logic [2:0] bbb;        // Addressing mode
                logic [1:0] cc;         // Group
        } opcode_fields_t;

        typedef union packed {
                logic [7:0] raw;
                opcode_fields_t fields;
        } opcode_u;

        typedef struct packed {
                alu_op_t alu_op;
                src_t src_a;
                logic use_operand;      // B from operand byte
                logic b_ones;           // B = 8'hFF, decrements
                logic invert_b;
                logic carry_sel;        // Carry in from C flag
                logic carry_one;
                dest_t dest;
                logic update_nz;
                logic update_cv;
                logic compare;          // Keeps V on update_cv
                flag_op_t flag_op;
                cond_t cond;
                logic [2:0] length;     // Instruction bytes
                logic illegal;
        } micro_op_t;

        typedef struct packed {
                logic [REG_WIDTH-1:0] a;
                logic [REG_WIDTH-1:0] x;
                logic [REG_WIDTH-1:0] y;
                logic [REG_WIDTH-1:0] p;
        } regs_t;

        typedef struct packed {
                logic n;
                logic z;
                logic c;
                logic v;
        } alu_flags_t;

endpackage

// ==== source/opcode_decoder.sv ====
// ##########################################################
// Opcode decoder: maps a captured opcode to a micro-op
// ##########################################################
module opcode_decoder (
        input core_pkg::opcode_u opcode_q,
        output core_pkg::micro_op_t uop
);
        import core_pkg::*;

        logic bad;
        micro_op_t dec;

        always_comb begin
                dec = '0;
                dec.length = 3'd1;
                bad = 1'b0;
                case (opcode_q.raw)
                        OP_INX, OP_DEX: begin
                                dec.alu_op = ALU_ADD;
                                dec.src_a = SRC_X;
                                dec.dest = DEST_X;
                                dec.b_ones = (opcode_q.raw == OP_DEX);
                                dec.update_nz = 1'b1;
                        end
                        OP_INY, OP_DEY: begin
                                dec.alu_op = ALU_ADD;
                                dec.src_a = SRC_Y;
                                dec.dest = DEST_Y;
                                dec.b_ones = (opcode_q.raw == OP_DEY);
                                dec.update_nz = 1'b1;
                        end
                        OP_CLC: dec.flag_op = CLEAR_C;
                        OP_SEC: dec.flag_op = SET_C;
                        OP_CLD: dec.flag_op = CLEAR_D;
                        OP_SED: dec.flag_op = SET_D;
                        OP_CLV: dec.flag_op = CLEAR_V;
                        OP_BPL: dec.cond = COND_PL;
                        OP_BCC: dec.cond = COND_CC;
                        OP_BCS: dec.cond = COND_CS;
                        OP_BNE: dec.cond = COND_NE;
                        OP_BEQ: dec.cond = COND_EQ;
                        OP_BVS: dec.cond = COND_VS;
                        default: begin
                                dec.length = 3'd2;
                                dec.use_operand = 1'b1;
                                dec.update_nz = 1'b1;
                                if (opcode_q.fields.cc == CC_ALU &&
                                    opcode_q.fields.bbb == BBB_ALU_IMM) begin
                                        dec.src_a = SRC_A;
                                        dec.dest = DEST_A;
                                        case (opcode_q.fields.aaa)
                                                AAA_ORA: dec.alu_op = ALU_OR;
                                                AAA_AND: dec.alu_op = ALU_AND;
                                                AAA_EOR: dec.alu_op = ALU_XOR;
                                                AAA_LOAD: dec.alu_op = ALU_PASS_B;  // LDA
                                                AAA_ADC, AAA_SBC: begin
                                                        dec.alu_op = ALU_ADD;
                                                        dec.carry_sel = 1'b1;
                                                        dec.invert_b = (opcode_q.fields.aaa == AAA_SBC);
                                                        dec.update_cv = 1'b1;
                                                end
                                                AAA_CMP: begin
                                                        dec.alu_op = ALU_ADD;
                                                        dec.invert_b = 1'b1;
                                                        dec.carry_one = 1'b1;
                                                        dec.dest = DEST_NONE;
                                                        dec.update_cv = 1'b1;
                                                        dec.compare = 1'b1;
                                                end
                                                default: bad = 1'b1;    // STA and memory ops
                                        endcase
                                end else if (opcode_q.fields.aaa == AAA_LOAD &&
                                             opcode_q.fields.bbb == BBB_LOAD_IMM &&
                                             (opcode_q.fields.cc == CC_LDX ||
                                              opcode_q.fields.cc == CC_LDY)) begin
                                        dec.alu_op = ALU_PASS_B;
                                        dec.dest = (opcode_q.fields.cc == CC_LDX) ? DEST_X : DEST_Y;
                                end else begin
                                        bad = 1'b1;
                                end
                        end
                endcase
                if (dec.cond != COND_NONE) dec.length = 3'd2;  // Offset byte follows
                if (bad) begin
                        dec = '0;
                        dec.length = 3'd1;
                        dec.illegal = 1'b1;
                end
                uop = dec;
        end

endmodule

// ==== source/step_sequencer.sv ====
// ##########################################################
// Step sequencer: latches an instruction, then commit, done
// ##########################################################
module step_sequencer (
        input logic clk,
        input logic reset_n,
        input logic instruction_ready,
        input logic [core_pkg::REG_WIDTH-1:0] instruction_in,
        input logic [core_pkg::REG_WIDTH-1:0] operand_in,
        output core_pkg::opcode_u opcode_q,
        output logic [core_pkg::REG_WIDTH-1:0] operand_q,
        output logic commit,
        output logic instruction_done
);
        logic busy;
        logic [1:0] step;       // Execution step within the instruction

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        busy <= 1'b0;
                        step <= '0;
                end else if (!busy && instruction_ready) begin
                        busy <= 1'b1;
                        step <= '0;
                end else if (busy) begin
                        step <= step + 2'd1;
                        if (step == 2'd1) busy <= 1'b0;
                end
        end

        // Instruction bytes
        always_ff @(posedge clk) begin
                if (!busy && instruction_ready) begin
                        opcode_q <= instruction_in;
                        operand_q <= operand_in;
                end
        end

        assign commit = busy && step == 2'd0;
        assign instruction_done = busy && step == 2'd1;

        a_no_strobe_busy: assert property (@(posedge clk) disable iff (!reset_n)
                busy |-> !instruction_ready);
        a_commit_done: assert property (@(posedge clk) disable iff (!reset_n)
                commit |=> instruction_done);

endmodule

// ==== source/alu.sv ====
// ##########################################################
// ALU: logic ops and add with carry, inverted B for subtract
// ##########################################################
module alu (
        input core_pkg::alu_op_t op,
        input logic [core_pkg::REG_WIDTH-1:0] a,
        input logic [core_pkg::REG_WIDTH-1:0] b,
        input logic carry_in,
        input logic invert_b,
        output logic [core_pkg::REG_WIDTH-1:0] result,
        output core_pkg::alu_flags_t flags
);
        import core_pkg::*;

        logic [REG_WIDTH-1:0] b_eff;
        logic [REG_WIDTH:0] sum;

        assign b_eff = invert_b ? ~b : b;
        assign sum = {1'b0, a} + {1'b0, b_eff} + {{REG_WIDTH{1'b0}}, carry_in};

        always_comb begin
                case (op)
                        ALU_OR: result = a | b;
                        ALU_AND: result = a & b;
                        ALU_XOR: result = a ^ b;
                        ALU_ADD: result = sum[REG_WIDTH-1:0];
                        default: result = b;    // Loads
                endcase
        end

        assign flags.n = result[REG_WIDTH-1];
        assign flags.z = (result == '0);
        assign flags.c = sum[REG_WIDTH];
        // Same operand signs, different result sign
        assign flags.v = (a[REG_WIDTH-1] == b_eff[REG_WIDTH-1]) &&
                         (sum[REG_WIDTH-1] != a[REG_WIDTH-1]);

endmodule

// ==== source/register_file.sv ====
// ##########################################################
// Register file: A, X, Y and status, written on commit
// ##########################################################
module register_file (
        input logic clk,
        input logic reset_n,
        input logic commit,
        input core_pkg::micro_op_t uop,
        input logic [core_pkg::REG_WIDTH-1:0] result,
        input core_pkg::alu_flags_t flags,
        output core_pkg::regs_t regs
);
        import core_pkg::*;

        logic [REG_WIDTH-1:0] p_next;

        always_comb begin
                p_next = regs.p;
                if (uop.update_nz) begin
                        p_next[FLAG_N] = flags.n;
                        p_next[FLAG_Z] = flags.z;
                end
                if (uop.update_cv) begin
                        p_next[FLAG_C] = flags.c;
                        if (!uop.compare) p_next[FLAG_V] = flags.v;
                end
                case (uop.flag_op)
                        CLEAR_C: p_next[FLAG_C] = 1'b0;
                        SET_C: p_next[FLAG_C] = 1'b1;
                        CLEAR_D: p_next[FLAG_D] = 1'b0;
                        SET_D: p_next[FLAG_D] = 1'b1;
                        CLEAR_V: p_next[FLAG_V] = 1'b0;
                        default: ;
                endcase
                p_next[5] = 1'b1;       // Unused bit reads as one
        end

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        regs <= '{a: '0, x: '0, y: '0, p: 8'h20};
                end else if (commit) begin
                        case (uop.dest)
                                DEST_A: regs.a <= result;
                                DEST_X: regs.x <= result;
                                DEST_Y: regs.y <= result;
                                default: ;
                        endcase
                        regs.p <= p_next;
                end
        end

endmodule

// ==== source/branch_unit.sv ====
// ##########################################################
// Branch unit: condition check and program counter
// ##########################################################
module branch_unit (
        input logic clk,
        input logic reset_n,
        input logic commit,
        input core_pkg::micro_op_t uop,
        input logic [core_pkg::REG_WIDTH-1:0] operand_q,
        input logic [core_pkg::REG_WIDTH-1:0] p,
        output logic [core_pkg::PC_WIDTH-1:0] pc
);
        import core_pkg::*;

        logic taken;
        logic [PC_WIDTH-1:0] target;

        always_comb begin
                case (uop.cond)
                        COND_PL: taken = !p[FLAG_N];
                        COND_CC: taken = !p[FLAG_C];
                        COND_CS: taken = p[FLAG_C];
                        COND_NE: taken = !p[FLAG_Z];
                        COND_EQ: taken = p[FLAG_Z];
                        COND_VS: taken = p[FLAG_V];
                        default: taken = 1'b0;
                endcase
        end

        // Offset is relative to the next instruction
        assign target = pc + PC_WIDTH'(2) +
                        {{(PC_WIDTH-REG_WIDTH){operand_q[REG_WIDTH-1]}}, operand_q};

        always_ff @(posedge clk) begin
                if (!reset_n) pc <= RESET_PC;
                else if (commit) pc <= taken ? target : pc + PC_WIDTH'(uop.length);
        end

endmodule

// ==== source/decoder_core.sv ====
// ##########################################################
// Execution core top for a 6502 instruction subset
// ##########################################################
module decoder_core (
        input logic clk,
        input logic reset_n,
        input logic instruction_ready,
        input logic [core_pkg::REG_WIDTH-1:0] instruction_in,
        input logic [core_pkg::REG_WIDTH-1:0] operand_in,
        output logic instruction_done,
        output logic illegal,
        output core_pkg::regs_t regs,
        output logic [core_pkg::PC_WIDTH-1:0] pc
);
        import core_pkg::*;

        opcode_u opcode_q;
        logic [REG_WIDTH-1:0] operand_q;
        logic commit;
        micro_op_t uop;
        logic [REG_WIDTH-1:0] alu_a, alu_b, result;
        logic alu_cin;
        alu_flags_t flags;

        step_sequencer u_seq (.clk, .reset_n, .instruction_ready, .instruction_in, .operand_in,
                .opcode_q, .operand_q, .commit, .instruction_done);

        opcode_decoder u_dec (.opcode_q, .uop);

        // ALU operand selection
        always_comb begin
                case (uop.src_a)
                        SRC_A: alu_a = regs.a;
                        SRC_X: alu_a = regs.x;
                        SRC_Y: alu_a = regs.y;
                        default: alu_a = '0;
                endcase
        end
        assign alu_b = uop.use_operand ? operand_q : (uop.b_ones ? '1 : REG_WIDTH'(1));
        assign alu_cin = uop.carry_sel ? regs.p[FLAG_C] : uop.carry_one;

        alu u_alu (.op(uop.alu_op), .a(alu_a), .b(alu_b), .carry_in(alu_cin),
                .invert_b(uop.invert_b), .result, .flags);

        register_file u_regs (.clk, .reset_n, .commit, .uop, .result, .flags, .regs);

        branch_unit u_branch (.clk, .reset_n, .commit, .uop, .operand_q, .p(regs.p), .pc);

        assign illegal = uop.illegal & instruction_done;

endmodule

// ==== testbench/tb_decoder_core.sv ====
// ##########################################################
// Testbench for the 6502 subset core: reference model,
// random stimulus and concurrent checks on the outputs
// ##########################################################
module tb_decoder_core;
        import core_pkg::*;

        logic clk;
        logic reset_n;
        logic instruction_ready;
        logic [7:0] instruction_in;
        logic [7:0] operand_in;
        logic instruction_done;
        logic illegal;
        regs_t regs;
        logic [PC_WIDTH-1:0] pc;

        regs_t exp_regs = '{a: 8'h00, x: 8'h00, y: 8'h00, p: 8'h20};
        logic [PC_WIDTH-1:0] exp_pc = RESET_PC;
        logic exp_illegal = 1'b0;
        logic in_flight = 1'b0;         // Strobe issued, done not yet seen
        logic [31:0] lcg_state = 32'h56e5b29b;
        int errors = 0;
        int timeouts = 0;
        logic [7:0] branch_ops [6] = '{8'h10, 8'h90, 8'hB0, 8'hD0, 8'hF0, 8'h70};
        logic [7:0] bad_ops [6] = '{8'h00, 8'h4C, 8'h89, 8'hA5, 8'h06, 8'hEA};

        decoder_core dut (.clk, .reset_n, .instruction_ready, .instruction_in, .operand_in,
                .instruction_done, .illegal, .regs, .pc);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic logic [7:0] random_byte();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state[23:16];
        endfunction

        // Reference model of one instruction, 6502 semantics
        task automatic predict(input logic [7:0] op, input logic [7:0] opnd);
                regs_t r;
                int s;                  // Signed view of the sum
                int u;                  // Unsigned view of the sum
                int cin;
                logic [7:0] res;
                logic taken;
                r = exp_regs;
                res = 8'h00;
                taken = 1'b0;
                exp_illegal = 1'b0;
                case (op)
                        8'hA9: res = opnd;              // LDA
                        8'h09: res = r.a | opnd;
                        8'h29: res = r.a & opnd;
                        8'h49: res = r.a ^ opnd;
                        8'h69, 8'hE9: begin             // ADC, SBC
                                cin = r.p[FLAG_C];
                                if (op == 8'h69) begin
                                        s = $signed(r.a) + $signed(opnd) + cin;
                                        u = r.a + opnd + cin;
                                        r.p[FLAG_C] = (u > 255);
                                end else begin
                                        s = $signed(r.a) - $signed(opnd) - (1 - cin);
                                        u = r.a - opnd - (1 - cin);
                                        r.p[FLAG_C] = (u >= 0);   // No borrow
                                end
                                res = s[7:0];
                                r.p[FLAG_V] = (s > 127) || (s < -128);
                        end
                        8'hC9: begin
                                res = r.a - opnd;
                                r.p[FLAG_C] = (r.a >= opnd);
                        end
                        8'hA2: r.x = opnd;
                        8'hA0: r.y = opnd;
                        8'hE8: r.x = r.x + 8'd1;
                        8'hCA: r.x = r.x - 8'd1;
                        8'hC8: r.y = r.y + 8'd1;
                        8'h88: r.y = r.y - 8'd1;
                        8'h18, 8'h38: r.p[FLAG_C] = (op == 8'h38);
                        8'hD8, 8'hF8: r.p[FLAG_D] = (op == 8'hF8);
                        8'hB8: r.p[FLAG_V] = 1'b0;
                        8'h10: taken = !r.p[FLAG_N];
                        8'h90: taken = !r.p[FLAG_C];
                        8'hB0: taken = r.p[FLAG_C];
                        8'hD0: taken = !r.p[FLAG_Z];
                        8'hF0: taken = r.p[FLAG_Z];
                        8'h70: taken = r.p[FLAG_V];
                        default: exp_illegal = 1'b1;
                endcase
                if (op inside {8'hA9, 8'h09, 8'h29, 8'h49, 8'h69, 8'hE9})
                        r.a = res;
                if (op inside {8'hA2, 8'hE8, 8'hCA})
                        res = r.x;
                if (op inside {8'hA0, 8'hC8, 8'h88})
                        res = r.y;
                if (op inside {8'hA9, 8'h09, 8'h29, 8'h49, 8'h69, 8'hE9, 8'hC9, 8'hA2, 8'hA0,
                               8'hE8, 8'hCA, 8'hC8, 8'h88}) begin
                        r.p[FLAG_N] = res[7];
                        r.p[FLAG_Z] = (res == 8'h00);
                end
                // Immediate forms and branches are two bytes, the rest one
                if (taken)
                        exp_pc = exp_pc + 16'd2 + {{8{opnd[7]}}, opnd};
                else if (op inside {8'hA9, 8'h09, 8'h29, 8'h49, 8'h69, 8'hE9, 8'hC9, 8'hA2, 8'hA0,
                                    8'h10, 8'h90, 8'hB0, 8'hD0, 8'hF0, 8'h70})
                        exp_pc = exp_pc + 16'd2;
                else
                        exp_pc = exp_pc + 16'd1;
                exp_regs = r;
        endtask

        // Called on a rising edge, returns on a rising edge
        task automatic execute(input logic [7:0] op, input logic [7:0] opnd);
                int cycles;
                predict(op, opnd);
                in_flight = 1'b1;
                instruction_ready <= 1'b1;
                instruction_in <= op;
                operand_in <= opnd;
                @(posedge clk);
                instruction_ready <= 1'b0;
                cycles = 0;
                do begin
                        @(negedge clk);
                        cycles++;
                end while (!instruction_done && cycles < 20);
                if (!instruction_done) begin
                        timeouts++;
                        $display("Timeout at %0t: no instruction_done for opcode %h", $time, op);
                end
                @(posedge clk);
                in_flight = 1'b0;
        endtask

        task automatic idle_gap();
                repeat (random_byte() % 3) @(posedge clk);
        endtask

        task automatic flags_high();            // N=1 Z=0 C=1 V=1
                execute(8'h18, random_byte());
                execute(8'hA9, 8'h40);
                execute(8'h69, 8'h40);
                execute(8'h38, random_byte());
        endtask

        task automatic flags_low();             // N=0 Z=1 C=0 V=0
                execute(8'hA9, 8'h00);
                execute(8'h18, random_byte());
                execute(8'hB8, random_byte());
        endtask

        a_regs: assert property (@(posedge clk) disable iff (!reset_n)
                (!in_flight || instruction_done) |-> regs == exp_regs)
                else begin
                        errors++;
                        $display("Fail time=%0t signal=regs expected=%h actual=%h", $time,
                                $sampled(exp_regs), $sampled(regs));
                end
        a_pc: assert property (@(posedge clk) disable iff (!reset_n)
                (!in_flight || instruction_done) |-> pc == exp_pc)
                else begin
                        errors++;
                        $display("Fail time=%0t signal=pc expected=%h actual=%h", $time,
                                $sampled(exp_pc), $sampled(pc));
                end
        a_illegal: assert property (@(posedge clk) disable iff (!reset_n)
                illegal == (instruction_done && exp_illegal))
                else begin
                        errors++;
                        $display("Fail time=%0t signal=illegal expected=%b actual=%b", $time,
                                $sampled(instruction_done && exp_illegal), $sampled(illegal));
                end
        a_done_timing: assert property (@(posedge clk) disable iff (!reset_n)
                instruction_ready |=> !instruction_done ##1 instruction_done ##1 !instruction_done)
                else begin
                        errors++;
                        $display("At %0t instruction_done did not pulse two cycles after the strobe",
                                $time);
                end
        a_idle_done: assert property (@(posedge clk) disable iff (!reset_n)
                !in_flight |-> !instruction_done)
                else begin
                        errors++;
                        $display("At %0t instruction_done pulsed with no instruction issued", $time);
                end

        initial begin
                logic [7:0] r8;
                reset_n = 1'b0;
                instruction_ready = 1'b0;
                instruction_in = 8'h00;
                operand_in = 8'h00;
                repeat (10) @(posedge clk);
                reset_n <= 1'b1;
                repeat (3) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                        if (i[0])
                                flags_high();   // C and V set, so a stray clear shows
                        execute(8'hA9, random_byte());
                        execute(8'hA2, random_byte());
                        execute(8'hA0, random_byte());
                        execute(8'h09, random_byte());
                        execute(8'h29, random_byte());
                        execute(8'h49, random_byte());
                        idle_gap();
                end
                for (int i = 0; i < 24; i++) begin
                        r8 = random_byte();
                        execute(r8[0] ? 8'h38 : 8'h18, random_byte());
                        execute(8'hA9, random_byte());
                        execute((i % 3 == 0) ? 8'h69 : (i % 3 == 1) ? 8'hE9 : 8'hC9, random_byte());
                end
                execute(8'hA9, 8'h5A);
                execute(8'hC9, 8'h5A);          // Equal compare
                execute(8'hA2, 8'hFF);
                execute(8'hE8, random_byte());  // X wraps to zero
                execute(8'hCA, random_byte());
                execute(8'hA0, 8'h00);
                execute(8'h88, random_byte());  // Y wraps to FF
                execute(8'hC8, random_byte());
                for (int i = 0; i < 8; i++) begin
                        r8 = random_byte();
                        execute((r8[1:0] == 2'd0) ? 8'hE8 : (r8[1:0] == 2'd1) ? 8'hC8 :
                                (r8[1:0] == 2'd2) ? 8'hCA : 8'h88, random_byte());
                end
                flags_high();
                execute(8'hB8, random_byte());
                execute(8'hF8, random_byte());
                execute(8'hD8, random_byte());
                execute(8'h18, random_byte());
                for (int k = 0; k < 4; k++) begin
                        for (int j = 0; j < 6; j++) begin
                                if (k[0])
                                        flags_high();
                                else
                                        flags_low();
                                r8 = random_byte();
                                execute(branch_ops[j], k[1] ? (r8 | 8'h80) : (r8 & 8'h7F));
                        end
                end
                foreach (bad_ops[i]) begin
                        execute(bad_ops[i], random_byte());
                        idle_gap();
                end
                repeat (2) @(posedge clk);
                $display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
                if (errors == 0 && timeouts == 0)
                        $display("Verification passed");
                else
                        $display("Verification failed");
                $finish;
        end

endmodule

// ==== decoder_core.f ====
source/core_pkg.sv
source/opcode_decoder.sv
source/step_sequencer.sv
source/alu.sv
source/register_file.sv
source/branch_unit.sv
source/decoder_core.sv
testbench/tb_decoder_core.sv

// ==== Bender.yml ====
package:
  name: decoder_core

sources:
  - source/core_pkg.sv
  - source/opcode_decoder.sv
  - source/step_sequencer.sv
  - source/alu.sv
  - source/register_file.sv
  - source/branch_unit.sv
  - source/decoder_core.sv
  - target: test
    files:
      - testbench/tb_decoder_core.sv
